// ==== Bender.yml ====
package:
  name: score_engine

sources:
  - include_dirs:
      - design
    files:
      - design/vecmat_pkg.sv
      - design/score_ctrl.sv
      - design/key_row_store.sv
      - design/lane_mul_array.sv
      - design/sum_tree.sv
      - design/score_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - verif/score_asserts.sv
      - verif/score_tb.sv

// ==== design/key_row_store.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module key_row_store (
	input  logic                 clk,
	input  vecmat_pkg::key_wr_t  key_wr,
	input  logic                 rd_en,
	input  vecmat_pkg::row_idx_t rd_addr,
	output vecmat_pkg::vec_t     rd_row
);

	vecmat_pkg::vec_t mem [`VM_ROWS];

	always_ff @(posedge clk) begin
		if (key_wr.en)
			mem[key_wr.addr] <= key_wr.row;
	end

	// Registered read, row shows up the next cycle.
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_row <= mem[rd_addr];
	end

endmodule

// ==== design/lane_mul_array.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module lane_mul_array (
	input  logic             clk,
	input  logic             reset,
	input  logic             load_q,
	input  vecmat_pkg::vec_t q,
	input  vecmat_pkg::vec_t k_row,
	output vecmat_pkg::vec_t prod
);

	vecmat_pkg::vec_t q_reg;
	vecmat_pkg::vec_t prod_next;

	always_ff @(posedge clk) begin
		if (!reset)
			q_reg <= '0;
		else if (load_q)
			q_reg <= q; // Held for the whole run.
	end

	for (genvar i = 0; i < `VM_LANES; i++) begin : g_lane
		logic signed [31:0] full;
		logic signed [31:0] scaled;

		assign full   = $signed(q_reg[i]) * $signed(k_row[i]);
		assign scaled = full >>> `VM_FRAC; // Back to Q8.8.
		assign prod_next[i] = vecmat_pkg::sat_elem(scaled);
	end

	always_ff @(posedge clk) begin
		prod <= prod_next;
	end

endmodule

// ==== design/score_ctrl.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module score_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  vecmat_pkg::row_cnt_t row_count,
	output logic                 rd_en,
	output vecmat_pkg::row_idx_t rd_addr,
	output logic                 tag_valid,
	output vecmat_pkg::row_idx_t tag_index,
	output logic                 busy,
	output logic                 done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_DRAIN
	} state_t;

	typedef struct packed {
		logic                 valid;
		vecmat_pkg::row_idx_t index;
	} tag_t;

	state_t               state;
	vecmat_pkg::row_idx_t issue_cnt;
	vecmat_pkg::row_idx_t last_idx;
	tag_t                 tag_sr [`VM_PIPE_DEPTH];
	logic                 accept;
	logic                 issue_last;

	assign busy       = (state != S_IDLE);
	assign accept     = start && !busy && (row_count != '0);
	assign rd_en      = (state == S_ISSUE);
	assign rd_addr    = issue_cnt;
	assign issue_last = (issue_cnt == last_idx);

	assign tag_valid = tag_sr[`VM_PIPE_DEPTH-1].valid; // Lines up with the tree output.
	assign tag_index = tag_sr[`VM_PIPE_DEPTH-1].index;
	assign done      = tag_valid && (tag_index == last_idx);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state     <= S_IDLE;
			issue_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						state     <= S_ISSUE;
						issue_cnt <= '0;
					end
				end
				S_ISSUE: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_last)
						state <= S_DRAIN;
				end
				S_DRAIN: begin
					if (done)
						state <= S_IDLE; // Last score leaves, busy drops next.
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			last_idx <= vecmat_pkg::row_idx_t'(row_count - 1'b1);
	end

	// Tag pipe, one entry per datapath stage.
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `VM_PIPE_DEPTH; i++)
				tag_sr[i].valid <= 1'b0;
		end else begin
			tag_sr[0].valid <= rd_en;
			for (int i = 1; i < `VM_PIPE_DEPTH; i++)
				tag_sr[i].valid <= tag_sr[i-1].valid;
		end
		tag_sr[0].index <= rd_addr;
		for (int i = 1; i < `VM_PIPE_DEPTH; i++)
			tag_sr[i].index <= tag_sr[i-1].index;
	end

endmodule

// ==== design/score_top.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module score_top (
	input  logic                 clk,
	input  logic                 reset,
	input  vecmat_pkg::key_wr_t  key_wr,
	input  logic                 start,
	input  vecmat_pkg::vec_t     q,
	input  vecmat_pkg::row_cnt_t row_count,
	output vecmat_pkg::score_t   score,
	output logic                 busy,
	output logic                 done
);

	logic                 rd_en;
	vecmat_pkg::row_idx_t rd_addr;
	logic                 tag_valid;
	vecmat_pkg::row_idx_t tag_index;
	vecmat_pkg::vec_t     rd_row;
	vecmat_pkg::vec_t     prod;
	vecmat_pkg::elem_t    sum;
	logic                 load_q;

	assign load_q = start && !busy; // A start during a run keeps Q.

	score_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.row_count (row_count),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.tag_valid (tag_valid),
		.tag_index (tag_index),
		.busy      (busy),
		.done      (done)
	);

	key_row_store u_store (
		.clk     (clk),
		.key_wr  (key_wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_row  (rd_row)
	);

	lane_mul_array u_mul (
		.clk    (clk),
		.reset  (reset),
		.load_q (load_q),
		.q      (q),
		.k_row  (rd_row),
		.prod   (prod)
	);

	sum_tree u_tree (
		.clk   (clk),
		.reset (reset),
		.prod  (prod),
		.sum   (sum)
	);

	assign score = '{valid: tag_valid, index: tag_index, value: sum};

endmodule

// ==== design/sum_tree.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module sum_tree (
	input  logic              clk,
	input  logic              reset,
	input  vecmat_pkg::vec_t  prod,
	output vecmat_pkg::elem_t sum
);

	localparam int LEVELS = $clog2(`VM_LANES);
	localparam int CUT    = 2; // Pipeline register after this level.

	vecmat_pkg::elem_t node [LEVELS+1][`VM_LANES];
	vecmat_pkg::elem_t cut_reg [`VM_LANES >> CUT];
	vecmat_pkg::elem_t root;

	for (genvar i = 0; i < `VM_LANES; i++) begin : g_leaf
		assign node[0][i] = prod[i];
	end

	// Adjacent pairs at every level.
	for (genvar l = 1; l <= LEVELS; l++) begin : g_level
		for (genvar i = 0; i < (`VM_LANES >> l); i++) begin : g_add
			vecmat_pkg::elem_t a;
			vecmat_pkg::elem_t b;

			if (l == CUT + 1) begin : g_from_reg
				assign a = cut_reg[2*i];
				assign b = cut_reg[2*i+1];
			end else begin : g_from_node
				assign a = node[l-1][2*i];
				assign b = node[l-1][2*i+1];
			end
			assign node[l][i] = vecmat_pkg::sat_add(a, b);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < (`VM_LANES >> CUT); i++)
			cut_reg[i] <= node[CUT][i];
	end

	if (LEVELS > CUT) begin : g_root_tree
		assign root = node[LEVELS][0];
	end else begin : g_root_cut
		assign root = cut_reg[0]; // Four lanes end at the cut.
	end

	always_ff @(posedge clk) begin
		if (!reset)
			sum <= '0;
		else
			sum <= root;
	end

endmodule

// ==== design/vecmat_macros.svh ====
`ifndef VECMAT_MACROS_SVH
`define VECMAT_MACROS_SVH

// Lanes per vector, each one 16-bit Q8.8 word.
`define VM_LANES 16

// Key rows held in the store.
`define VM_ROWS 32

// Fraction bits of the fixed-point format.
`define VM_FRAC 8

// Cycles from a row read issue to its score at the top level.
`define VM_PIPE_DEPTH 4

`endif

// ==== design/vecmat_pkg.sv ====
`include "vecmat_macros.svh"

package vecmat_pkg;

	localparam int ROW_W = $clog2(`VM_ROWS);

	typedef logic signed [15:0] elem_t; // Q8.8 word.

	typedef elem_t [`VM_LANES-1:0] vec_t; // Lane 0 in the low bits.

	typedef logic [ROW_W-1:0] row_idx_t;

	typedef logic [ROW_W:0] row_cnt_t; // Holds 1 to VM_ROWS.

	typedef struct packed {
		logic     en;
		row_idx_t addr;
		vec_t     row;
	} key_wr_t;

	typedef struct packed {
		logic     valid;
		row_idx_t index;
		elem_t    value;
	} score_t;

	// Clamp a wide signed value into one word.
	function automatic elem_t sat_elem(input logic signed [31:0] x);
		if (x > 32'sd32767)
			return 16'sh7fff;
		if (x < -32'sd32768)
			return 16'sh8000;
		return elem_t'(x);
	endfunction

	function automatic elem_t sat_add(input elem_t a, input elem_t b);
		return sat_elem(32'(a) + 32'(b));
	endfunction

endpackage

// ==== project.f ====
+incdir+design
design/vecmat_pkg.sv
design/score_ctrl.sv
design/key_row_store.sv
design/lane_mul_array.sv
design/sum_tree.sv
design/score_top.sv
verif/score_asserts.sv
verif/score_tb.sv

// ==== verif/score_asserts.sv ====
`timescale 1ns/1ps

module score_asserts (
	input logic               clk,
	input logic               reset,
	input vecmat_pkg::score_t score,
	input logic               busy,
	input logic               done
);

	int fail_count = 0; // Read by the testbench at the end.

	a_done_ends_stream: assert property (@(posedge clk) disable iff (!reset)
		done |=> !score.valid)
		else begin
			fail_count++;
			$error("score still valid the cycle after done");
		end

	a_score_while_busy: assert property (@(posedge clk) disable iff (!reset)
		score.valid |-> busy)
		else begin
			fail_count++;
			$error("score valid while busy is low");
		end

	a_idle_after_done: assert property (@(posedge clk) disable iff (!reset)
		done |=> !busy)
		else begin
			fail_count++;
			$error("busy still high the cycle after done");
		end

endmodule

bind score_top score_asserts asserts_i (
	.clk   (clk),
	.reset (reset),
	.score (score),
	.busy  (busy),
	.done  (done)
);

// ==== verif/score_tb.sv ====
`timescale 1ns/1ps
`include "vecmat_macros.svh"

module score_tb;

	localparam int KIND_SMALL  = 0;
	localparam int KIND_LARGE  = 1;
	localparam int KIND_RANDOM = 2;

	typedef struct {
		string name;
		int    kind;
		int    rows;
		bit    restart;
	} case_t;

	logic                 clk;
	logic                 reset;
	logic                 start;
	vecmat_pkg::key_wr_t  key_wr;
	vecmat_pkg::vec_t     q;
	vecmat_pkg::row_cnt_t row_count;
	vecmat_pkg::score_t   score;
	logic                 busy;
	logic                 done;

	int          cyc = 0;
	logic [31:0] lcg_state;
	case_t       cases [$];

	score_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.key_wr    (key_wr),
		.start     (start),
		.q         (q),
		.row_count (row_count),
		.score     (score),
		.busy      (busy),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16]; // Upper bits are the better ones.
	endfunction

	function automatic vecmat_pkg::elem_t clamp16(input int x);
		if (x > 32767)
			return 16'sh7fff;
		if (x < -32768)
			return 16'sh8000;
		return vecmat_pkg::elem_t'(x);
	endfunction

	// Q8.8 products, then adjacent pairs level by level.
	function automatic vecmat_pkg::elem_t ref_dot(input vecmat_pkg::vec_t a,
			input vecmat_pkg::vec_t b);
		vecmat_pkg::elem_t lvl [`VM_LANES];
		int n;
		for (int i = 0; i < `VM_LANES; i++)
			lvl[i] = clamp16((int'(a[i]) * int'(b[i])) >>> `VM_FRAC);
		n = `VM_LANES;
		while (n > 1) begin
			for (int i = 0; i < n / 2; i++)
				lvl[i] = clamp16(int'(lvl[2*i]) + int'(lvl[2*i+1]));
			n = n / 2;
		end
		return lvl[0];
	endfunction

	// Row below zero selects the Q vector.
	function automatic vecmat_pkg::elem_t make_elem(input int kind, input int lane,
			input int row);
		logic [15:0] r;
		case (kind)
			KIND_SMALL: begin
				if (row < 0)
					return vecmat_pkg::elem_t'(((lane % 5) - 2) * 256);
				return vecmat_pkg::elem_t'((((lane + 2 * row) % 7) - 3) * 256);
			end
			KIND_LARGE: begin
				r = rand16();
				if (r[15])
					return vecmat_pkg::elem_t'({2'b10, r[13:0]}); // At most -64.0.
				return vecmat_pkg::elem_t'({2'b01, r[13:0]}); // At least 64.0.
			end
			default: return vecmat_pkg::elem_t'(rand16());
		endcase
	endfunction

	task automatic fail_now();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_score(input string name, input vecmat_pkg::row_idx_t exp_idx,
			input vecmat_pkg::elem_t exp_val, input vecmat_pkg::row_idx_t act_idx,
			input vecmat_pkg::elem_t act_val);
		if (act_idx !== exp_idx || act_val !== exp_val) begin
			$display("FAIL %s: expected index %0d value %h, actual index %0d value %h",
				name, exp_idx, exp_val, act_idx, act_val);
			fail_now();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_cycle(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL %s: expected cycle %0d, actual cycle %0d", name, exp, act);
			fail_now();
		end
	endtask

	task automatic run_case(input case_t c);
		vecmat_pkg::vec_t  qv;
		vecmat_pkg::vec_t  keys [`VM_ROWS];
		vecmat_pkg::elem_t exp_val [`VM_ROWS];
		int start_cyc;
		int got;
		int waited;
		for (int i = 0; i < `VM_LANES; i++)
			qv[i] = make_elem(c.kind, i, -1);
		for (int r = 0; r < c.rows; r++) begin
			for (int i = 0; i < `VM_LANES; i++)
				keys[r][i] = make_elem(c.kind, i, r);
			exp_val[r] = ref_dot(qv, keys[r]);
		end
		for (int r = 0; r < c.rows; r++) begin
			@(posedge clk);
			key_wr <= '{en: 1'b1, addr: vecmat_pkg::row_idx_t'(r), row: keys[r]};
		end
		@(posedge clk);
		key_wr.en <= 1'b0;
		start     <= 1'b1;
		q         <= qv;
		row_count <= vecmat_pkg::row_cnt_t'(c.rows);
		@(negedge clk);
		start_cyc = cyc;
		@(posedge clk);
		start     <= 1'b0;
		q         <= '0; // Q must already be latched.
		row_count <= vecmat_pkg::row_cnt_t'(1);
		for (waited = 0; waited < 8; waited++) begin
			@(negedge clk);
			if (busy === 1'b1)
				break;
		end
		if (busy !== 1'b1) begin
			$display("Timeout: busy never rose in case %s", c.name);
			fail_now();
		end
		got = 0;
		waited = 0;
		while (got < c.rows) begin
			@(posedge clk);
			if (c.restart && got == 1) begin
				start     <= 1'b1; // Must be ignored while busy.
				q         <= ~qv;
				row_count <= vecmat_pkg::row_cnt_t'(3);
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
			if (score.valid === 1'b1) begin
				check_score(c.name, vecmat_pkg::row_idx_t'(got), exp_val[got],
					score.index, score.value);
				check_cycle({c.name, " timing"}, start_cyc + 5 + got, cyc);
				check_flag({c.name, " done"}, got == c.rows - 1, done);
				check_flag({c.name, " busy"}, 1'b1, busy);
				got++;
			end else if (got > 0) begin
				check_flag({c.name, " valid stream"}, 1'b1, score.valid);
			end else begin
				check_flag({c.name, " early done"}, 1'b0, done);
				waited++;
				if (waited > 16) begin
					$display("Timeout: no score arrived in case %s", c.name);
					fail_now();
				end
			end
		end
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_flag({c.name, " busy after done"}, 1'b0, busy);
		repeat (6) begin
			@(negedge clk);
			check_flag({c.name, " extra score"}, 1'b0, score.valid);
			check_flag({c.name, " idle busy"}, 1'b0, busy);
		end
	endtask

	initial begin
		reset     = 1'b0;
		start     = 1'b0;
		key_wr    = '0;
		q         = '0;
		row_count = '0;
		lcg_state = 32'hdce4_919d;
		cases.push_back('{name: "small_one_row", kind: KIND_SMALL, rows: 1, restart: 0});
		cases.push_back('{name: "small_eight", kind: KIND_SMALL, rows: 8, restart: 0});
		cases.push_back('{name: "large_sat", kind: KIND_LARGE, rows: 6, restart: 0});
		cases.push_back('{name: "small_full", kind: KIND_SMALL, rows: `VM_ROWS, restart: 0});
		cases.push_back('{name: "restart_busy", kind: KIND_SMALL, rows: 10, restart: 1});
		for (int k = 0; k < 20; k++)
			cases.push_back('{name: $sformatf("random_%0d", k), kind: KIND_RANDOM,
				rows: (rand16() % `VM_ROWS) + 1, restart: 0});
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		repeat (5) begin
			@(negedge clk);
			check_flag("idle valid", 1'b0, score.valid);
			check_flag("idle busy", 1'b0, busy);
			check_flag("idle done", 1'b0, done);
		end
		foreach (cases[k])
			run_case(cases[k]);
		if (dut_i.asserts_i.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
